// ==== dv/tb_decoder_tasks.svh ====
// expected alu control word
function automatic pic_decode_pkg::alu_ctrl_t alu_fields(
	input logic sel,
	input pic_decode_pkg::alu_op_e op,
	input logic st
);
	pic_decode_pkg::alu_ctrl_t a;
	a.sel_l = sel;
	a.op = op;
	a.status_wr_en = st;
	return a;
endfunction

// phase-3 controls from flow kind and condition inputs
function automatic pic_decode_pkg::seq_ctrl_t seq_expected(
	input pic_decode_pkg::flow_e flow,
	input logic irq,
	input logic z,
	input logic bt
);
	pic_decode_pkg::seq_ctrl_t s;
	logic skip;
	s = '0;
	skip = (flow == pic_decode_pkg::flow_skip_z) ? z : bt; // condition for this skip
	if (flow == pic_decode_pkg::flow_seq) begin
		s.instr_rd_en = ~irq;
		s.pc_incr_en = ~irq;
		s.instr_flush = irq; // isr entry replaces the advance
		s.pc_j_to_isr = irq;
		s.gie_clr_en = irq;
	end else if (flow == pic_decode_pkg::flow_skip_z ||
		flow == pic_decode_pkg::flow_skip_bit) begin
		s.pc_incr_en = 1'b1; // irq never taken here
		s.instr_flush = skip;
		s.instr_rd_en = ~skip;
	end else if (flow != pic_decode_pkg::flow_none) begin
		s.instr_flush = 1'b1; // all branches drop the prefetch
		s.pc_j_en = (flow == pic_decode_pkg::flow_jump);
		s.pc_j_and_push_en = (flow == pic_decode_pkg::flow_call);
		s.pc_j_by_pop_en = (flow == pic_decode_pkg::flow_ret) ||
			(flow == pic_decode_pkg::flow_retfie);
		s.gie_set_en = (flow == pic_decode_pkg::flow_retfie);
	end
	return s;
endfunction

// every control low
task automatic expect_idle(input string where);
	if (alu !== '0) begin
		$display("Mismatch alu (%s): got %h, expected %h", where, alu, 6'h00);
		errors = errors + 1;
	end
	if (w_wr_en !== 1'b0 || f_wr_en !== 1'b0) begin
		$display("Mismatch w_wr_en/f_wr_en (%s): got %h/%h, expected 0/0", where, w_wr_en,
			f_wr_en);
		errors = errors + 1;
	end
	if (seq !== '0) begin
		$display("Mismatch seq (%s): got %h, expected %h", where, seq, 9'h000);
		errors = errors + 1;
	end
endtask

// clkout pattern and quiet phases 0 and 1 right after reset
task automatic phase_rhythm();
	int ph;
	ph = 1; // first falling edge after release sits in phase 1
	repeat (12) begin
		@(negedge clk);
		if (clkout !== (ph < 2)) begin
			$display("Mismatch clkout (phase %0d): got %h, expected %h", ph, clkout, ph < 2);
			errors = errors + 1;
		end
		if (ph < 2)
			expect_idle("phase 0/1 after reset");
		ph = (ph + 1) % 4;
	end
endtask

// one instruction cycle, inputs set in phase 0
task automatic run_word(
	input string name,
	input pic_decode_pkg::instr_t word,
	input logic irq,
	input logic z,
	input logic bt,
	input pic_decode_pkg::alu_ctrl_t exp_alu,
	input logic exp_w,
	input logic exp_f,
	input pic_decode_pkg::flow_e flow
);
	pic_decode_pkg::seq_ctrl_t exp_seq;
	exp_seq = seq_expected(flow, irq, z, bt);
	@(posedge clkout); // phase 0 starts
	@(negedge clk);
	expect_idle(name); // previous word still applied
	instr_current = word;
	interrupt_flag = irq;
	status_z = z;
	bit_test_res = bt;
	@(negedge clk); // phase 1
	expect_idle(name);
	@(negedge clkout); // into phase 2
	@(negedge clk);
	if (alu !== exp_alu) begin
		$display("Mismatch alu (%s): got %h, expected %h", name, alu, exp_alu);
		errors = errors + 1;
	end
	if (w_wr_en !== exp_w) begin
		$display("Mismatch w_wr_en (%s): got %h, expected %h", name, w_wr_en, exp_w);
		errors = errors + 1;
	end
	if (f_wr_en !== exp_f) begin
		$display("Mismatch f_wr_en (%s): got %h, expected %h", name, f_wr_en, exp_f);
		errors = errors + 1;
	end
	if (seq !== '0) begin
		$display("Mismatch seq (%s, phase 2): got %h, expected %h", name, seq, 9'h000);
		errors = errors + 1;
	end
	@(negedge clk); // phase 3
	if (seq !== exp_seq) begin
		$display("Mismatch seq (%s): got %h, expected %h", name, seq, exp_seq);
		errors = errors + 1;
	end
	if (alu !== '0 || w_wr_en !== 1'b0 || f_wr_en !== 1'b0) begin
		$display("Mismatch alu/w_wr_en/f_wr_en (%s, phase 3): got %h/%h/%h, expected 0/0/0",
			name, alu, w_wr_en, f_wr_en);
		errors = errors + 1;
	end
endtask

// byte op with d = 0 then d = 1
task automatic byte_op_pair(
	input string name,
	input logic [5:0] opc,
	input pic_decode_pkg::alu_op_e op,
	input logic st,
	input logic skips
);
	logic [31:0] r;
	pic_decode_pkg::flow_e flow;
	flow = skips ? pic_decode_pkg::flow_skip_z : pic_decode_pkg::flow_seq;
	for (int d = 0; d < 2; d++) begin
		r = $urandom; // file address, no effect on controls
		run_word(name, {opc, d[0], r[6:0]}, 1'b0, 1'b0, 1'b0,
			alu_fields(1'b0, op, st), ~d[0], d[0], flow);
	end
endtask

task automatic byte_and_bit_ops();
	logic [31:0] r;
	byte_op_pair("addwf", 6'b000111, pic_decode_pkg::alu_add, 1'b1, 1'b0);
	byte_op_pair("andwf", 6'b000101, pic_decode_pkg::alu_and, 1'b1, 1'b0);
	byte_op_pair("clrw/clrf", 6'b000001, pic_decode_pkg::alu_zero, 1'b1, 1'b0);
	byte_op_pair("comf", 6'b001001, pic_decode_pkg::alu_com, 1'b1, 1'b0);
	byte_op_pair("decf", 6'b000011, pic_decode_pkg::alu_dec, 1'b1, 1'b0);
	byte_op_pair("decfsz", 6'b001011, pic_decode_pkg::alu_dec, 1'b1, 1'b1);
	byte_op_pair("incf", 6'b001010, pic_decode_pkg::alu_inc, 1'b1, 1'b0);
	byte_op_pair("incfsz", 6'b001111, pic_decode_pkg::alu_inc, 1'b1, 1'b1);
	byte_op_pair("iorwf", 6'b000100, pic_decode_pkg::alu_or, 1'b1, 1'b0);
	byte_op_pair("movf", 6'b001000, pic_decode_pkg::alu_passlf, 1'b1, 1'b0);
	byte_op_pair("rlf", 6'b001101, pic_decode_pkg::alu_rlf, 1'b1, 1'b0);
	byte_op_pair("rrf", 6'b001100, pic_decode_pkg::alu_rrf, 1'b1, 1'b0);
	byte_op_pair("subwf", 6'b000010, pic_decode_pkg::alu_sub, 1'b1, 1'b0);
	byte_op_pair("swapf", 6'b001110, pic_decode_pkg::alu_swapf, 1'b0, 1'b0); // no status
	byte_op_pair("xorwf", 6'b000110, pic_decode_pkg::alu_xor, 1'b1, 1'b0);
	r = $urandom; // bit number and address
	run_word("movwf", {7'b0000001, r[6:0]}, 1'b0, 1'b0, 1'b0,
		alu_fields(1'b0, pic_decode_pkg::alu_passw, 1'b0), 1'b0, 1'b1, pic_decode_pkg::flow_seq);
	run_word("bcf", {4'b0100, r[9:0]}, 1'b0, 1'b0, 1'b0,
		alu_fields(1'b0, pic_decode_pkg::alu_bc, 1'b1), 1'b0, 1'b1, pic_decode_pkg::flow_seq);
	run_word("bsf", {4'b0101, r[19:10]}, 1'b0, 1'b0, 1'b0,
		alu_fields(1'b0, pic_decode_pkg::alu_bs, 1'b1), 1'b0, 1'b1, pic_decode_pkg::flow_seq);
	run_word("btfsc", {4'b0110, r[29:20]}, 1'b0, 1'b0, 1'b0,
		alu_fields(1'b0, pic_decode_pkg::alu_bc, 1'b0), 1'b0, 1'b0,
		pic_decode_pkg::flow_skip_bit);
	run_word("btfss", {4'b0111, r[9:0]}, 1'b0, 1'b0, 1'b0,
		alu_fields(1'b0, pic_decode_pkg::alu_bs, 1'b0), 1'b0, 1'b0,
		pic_decode_pkg::flow_skip_bit);
endtask

// literal op, k random
task automatic literal_op(
	input string name,
	input logic [5:0] pre,
	input pic_decode_pkg::alu_op_e op,
	input logic st,
	input logic is_ret
);
	logic [31:0] r;
	r = $urandom;
	run_word(name, {pre, r[7:0]}, 1'b0, 1'b0, 1'b0, alu_fields(1'b1, op, st), 1'b1, 1'b0,
		is_ret ? pic_decode_pkg::flow_ret : pic_decode_pkg::flow_seq);
endtask

task automatic literal_ops();
	literal_op("addlw", 6'b111110, pic_decode_pkg::alu_add, 1'b1, 1'b0);
	literal_op("andlw", 6'b111001, pic_decode_pkg::alu_and, 1'b1, 1'b0);
	literal_op("iorlw", 6'b111000, pic_decode_pkg::alu_or, 1'b1, 1'b0);
	literal_op("movlw", 6'b110000, pic_decode_pkg::alu_passlf, 1'b0, 1'b0);
	literal_op("sublw", 6'b111100, pic_decode_pkg::alu_sub, 1'b1, 1'b0);
	literal_op("xorlw", 6'b111010, pic_decode_pkg::alu_xor, 1'b1, 1'b0);
	literal_op("retlw", 6'b110100, pic_decode_pkg::alu_passlf, 1'b0, 1'b1);
endtask

// plain advance, then isr entry with the flag set
task automatic advance_and_interrupt();
	logic [31:0] r;
	for (int i = 0; i < 2; i++) begin
		r = $urandom;
		run_word("nop", 14'h0000, i[0], 1'b0, 1'b0, '0, 1'b0, 1'b0, pic_decode_pkg::flow_seq);
		run_word("incf", {6'b001010, 1'b0, r[6:0]}, i[0], 1'b0, 1'b0,
			alu_fields(1'b0, pic_decode_pkg::alu_inc, 1'b1), 1'b1, 1'b0,
			pic_decode_pkg::flow_seq);
	end
endtask

// both condition values, each with irq low and high
task automatic skip_cases(
	input string name,
	input pic_decode_pkg::instr_t word,
	input pic_decode_pkg::alu_ctrl_t exp_alu,
	input logic exp_f,
	input logic on_bit
);
	logic cond;
	pic_decode_pkg::flow_e flow;
	flow = on_bit ? pic_decode_pkg::flow_skip_bit : pic_decode_pkg::flow_skip_z;
	for (int c = 0; c < 2; c++) begin
		for (int i = 0; i < 2; i++) begin
			cond = c[0];
			// unused condition input driven opposite
			run_word(name, word, i[0], on_bit ? ~cond : cond, on_bit ? cond : ~cond,
				exp_alu, 1'b0, exp_f, flow);
		end
	end
endtask

task automatic skip_ops();
	logic [31:0] r;
	r = $urandom;
	skip_cases("decfsz", {6'b001011, 1'b1, r[6:0]},
		alu_fields(1'b0, pic_decode_pkg::alu_dec, 1'b1), 1'b1, 1'b0);
	skip_cases("incfsz", {6'b001111, 1'b1, r[13:7]},
		alu_fields(1'b0, pic_decode_pkg::alu_inc, 1'b1), 1'b1, 1'b0);
	skip_cases("btfsc", {4'b0110, r[23:14]},
		alu_fields(1'b0, pic_decode_pkg::alu_bc, 1'b0), 1'b0, 1'b1);
	skip_cases("btfss", {4'b0111, r[31:22]},
		alu_fields(1'b0, pic_decode_pkg::alu_bs, 1'b0), 1'b0, 1'b1);
endtask

task automatic branches_and_unknown();
	logic [31:0] r;
	r = $urandom; // branch targets
	run_word("goto", {3'b101, r[10:0]}, 1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0,
		pic_decode_pkg::flow_jump);
	run_word("call", {3'b100, r[21:11]}, 1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0,
		pic_decode_pkg::flow_call);
	run_word("return", 14'h0008, 1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0, pic_decode_pkg::flow_ret);
	run_word("retfie", 14'h0009, 1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0,
		pic_decode_pkg::flow_retfie);
	// dropped words, silent even with every input high
	run_word("clrwdt", 14'h0064, 1'b1, 1'b1, 1'b1, '0, 1'b0, 1'b0, pic_decode_pkg::flow_none);
	run_word("sleep", 14'h0063, 1'b1, 1'b1, 1'b1, '0, 1'b0, 1'b0, pic_decode_pkg::flow_none);
endtask

// ==== dv/tb_instr_decoder.sv ====
`timescale 1ns/1ps
`include "pic_decode_consts.svh"

module tb_instr_decoder;

	// about 70 words of 4 cycles are run, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst;
	pic_decode_pkg::instr_t instr_current;
	logic interrupt_flag;
	logic status_z;
	logic bit_test_res;
	logic clkout; // high in phases 0 and 1
	pic_decode_pkg::alu_ctrl_t alu;
	logic w_wr_en;
	logic f_wr_en;
	pic_decode_pkg::seq_ctrl_t seq;
	int errors; // failed checks so far
	int cycle_cnt; // clocks since start

	instr_decoder u_dut (
		.clk (clk),
		.rst (rst),
		.instr_current (instr_current),
		.interrupt_flag (interrupt_flag),
		.status_z (status_z),
		.bit_test_res (bit_test_res),
		.clkout (clkout),
		.alu (alu),
		.w_wr_en (w_wr_en),
		.f_wr_en (f_wr_en),
		.seq (seq)
	);

	`include "tb_decoder_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// hang guard
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the directed tests did not finish within %0d cycles", cycle_cnt);
			$display("errors: %0d", errors + 1);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(3)); // single seed for the run
		errors = 0;
		cycle_cnt = 0;
		rst = 1'b1;
		instr_current = 14'b10_1000_0000_0000; // goto, must stay silent in reset
		interrupt_flag = 1'b1;
		status_z = 1'b0;
		bit_test_res = 1'b0;
		repeat (4) begin
			@(negedge clk);
			expect_idle("reset");
			if (clkout !== 1'b1) begin
				$display("Mismatch clkout (reset): got %h, expected %h", clkout, 1'b1);
				errors = errors + 1;
			end
		end
		rst = 1'b0; // released on a falling edge
		phase_rhythm();
		byte_and_bit_ops();
		literal_ops();
		advance_and_interrupt();
		skip_ops();
		branches_and_unknown();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== pic_decode.f ====
+incdir+verilog
+incdir+dv
verilog/pic_decode_pkg.sv
verilog/q_phase_gen.sv
verilog/opcode_classify.sv
verilog/alu_ctrl_gen.sv
verilog/seq_ctrl_gen.sv
verilog/instr_decoder.sv
dv/tb_instr_decoder.sv

// ==== verilog/alu_ctrl_gen.sv ====
`timescale 1ns/1ps
`include "pic_decode_consts.svh"

module alu_ctrl_gen (
	input logic [`PIC_PHASE_W-1:0] phase,
	input pic_decode_pkg::alu_ctrl_t alu_in,
	input pic_decode_pkg::dest_e dest,
	input logic dest_bit,
	output pic_decode_pkg::alu_ctrl_t alu,
	output logic w_wr_en,
	output logic f_wr_en
);

	logic exec_ph; // q3 of the cycle
	logic to_w; // result goes to w
	logic to_f; // result goes to f

	assign exec_ph = (phase == `PIC_PHASE_W'(`PIC_PH_EXEC));

	always_comb begin
		to_w = 1'b0;
		to_f = 1'b0;
		case (dest)
			pic_decode_pkg::dest_w: to_w = 1'b1;
			pic_decode_pkg::dest_f: to_f = 1'b1;
			pic_decode_pkg::dest_by_d: begin
				to_w = ~dest_bit; // d = 0
				to_f = dest_bit; // d = 1
			end
			default: begin
				to_w = 1'b0; // test-only and control words
				to_f = 1'b0;
			end
		endcase
	end

	// everything idle outside the execute phase
	assign alu = exec_ph ? alu_in : '0;
	assign w_wr_en = exec_ph & to_w;
	assign f_wr_en = exec_ph & to_f;

endmodule

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps
`include "pic_decode_consts.svh"

module instr_decoder (
	input logic clk,
	input logic rst,
	input pic_decode_pkg::instr_t instr_current,
	input logic interrupt_flag,
	input logic status_z,
	input logic bit_test_res,
	output logic clkout,
	output pic_decode_pkg::alu_ctrl_t alu,
	output logic w_wr_en,
	output logic f_wr_en,
	output pic_decode_pkg::seq_ctrl_t seq
);

	logic [`PIC_PHASE_W-1:0] phase; // current q phase
	pic_decode_pkg::decoded_t decoded; // table lookup of instr_current

	q_phase_gen u_q_phase_gen (
		.clk (clk),
		.rst (rst),
		.phase (phase),
		.clkout (clkout)
	);

	opcode_classify u_opcode_classify (
		.instr (instr_current),
		.decoded (decoded)
	);

	// phase 2, alu and register writes
	alu_ctrl_gen u_alu_ctrl_gen (
		.phase (phase),
		.alu_in (decoded.alu),
		.dest (decoded.dest),
		.dest_bit (instr_current[`PIC_DEST_BIT]),
		.alu (alu),
		.w_wr_en (w_wr_en),
		.f_wr_en (f_wr_en)
	);

	// phase 3, fetch and pc
	seq_ctrl_gen u_seq_ctrl_gen (
		.phase (phase),
		.flow (decoded.flow),
		.interrupt_flag (interrupt_flag),
		.status_z (status_z),
		.bit_test_res (bit_test_res),
		.seq (seq)
	);

endmodule

// ==== verilog/opcode_classify.sv ====
`timescale 1ns/1ps
`include "pic_decode_consts.svh"

module opcode_classify (
	input pic_decode_pkg::instr_t instr,
	output pic_decode_pkg::decoded_t decoded
);

	// general record builder
	function automatic pic_decode_pkg::decoded_t rec(
		input logic use_lit,
		input pic_decode_pkg::alu_op_e fn,
		input logic st_wr,
		input pic_decode_pkg::dest_e dst,
		input pic_decode_pkg::flow_e kind
	);
		pic_decode_pkg::decoded_t d;
		d.alu.sel_l = use_lit;
		d.alu.op = fn;
		d.alu.status_wr_en = st_wr;
		d.dest = dst;
		d.flow = kind;
		return d;
	endfunction

	// byte op on f, result to w or f by the d bit
	function automatic pic_decode_pkg::decoded_t byte_op(
		input pic_decode_pkg::alu_op_e fn,
		input logic st_wr,
		input pic_decode_pkg::flow_e kind
	);
		return rec(1'b0, fn, st_wr, pic_decode_pkg::dest_by_d, kind);
	endfunction

	// literal op, result always to w
	function automatic pic_decode_pkg::decoded_t lit_op(
		input pic_decode_pkg::alu_op_e fn,
		input logic st_wr,
		input pic_decode_pkg::flow_e kind
	);
		return rec(1'b1, fn, st_wr, pic_decode_pkg::dest_w, kind);
	endfunction

	// control-only word, no alu and no write
	function automatic pic_decode_pkg::decoded_t ctl_op(
		input pic_decode_pkg::flow_e kind
	);
		return rec(1'b0, pic_decode_pkg::alu_add, 1'b0, pic_decode_pkg::dest_none, kind);
	endfunction

	always_comb begin
		decoded = '0; // flow none, dest none
		casez (instr)
			// byte-oriented file ops
			14'b00_0111_????_????: decoded = byte_op(pic_decode_pkg::alu_add, 1'b1,
				pic_decode_pkg::flow_seq); // addwf
			14'b00_0101_????_????: decoded = byte_op(pic_decode_pkg::alu_and, 1'b1,
				pic_decode_pkg::flow_seq); // andwf
			14'b00_0001_????_????: decoded = byte_op(pic_decode_pkg::alu_zero, 1'b1,
				pic_decode_pkg::flow_seq); // clrf when d is 1, clrw when d is 0
			14'b00_1001_????_????: decoded = byte_op(pic_decode_pkg::alu_com, 1'b1,
				pic_decode_pkg::flow_seq); // comf
			14'b00_0011_????_????: decoded = byte_op(pic_decode_pkg::alu_dec, 1'b1,
				pic_decode_pkg::flow_seq); // decf
			14'b00_1011_????_????: decoded = byte_op(pic_decode_pkg::alu_dec, 1'b1,
				pic_decode_pkg::flow_skip_z); // decfsz
			14'b00_1010_????_????: decoded = byte_op(pic_decode_pkg::alu_inc, 1'b1,
				pic_decode_pkg::flow_seq); // incf
			14'b00_1111_????_????: decoded = byte_op(pic_decode_pkg::alu_inc, 1'b1,
				pic_decode_pkg::flow_skip_z); // incfsz
			14'b00_0100_????_????: decoded = byte_op(pic_decode_pkg::alu_or, 1'b1,
				pic_decode_pkg::flow_seq); // iorwf
			14'b00_1000_????_????: decoded = byte_op(pic_decode_pkg::alu_passlf, 1'b1,
				pic_decode_pkg::flow_seq); // movf sets z
			14'b00_1101_????_????: decoded = byte_op(pic_decode_pkg::alu_rlf, 1'b1,
				pic_decode_pkg::flow_seq); // rlf
			14'b00_1100_????_????: decoded = byte_op(pic_decode_pkg::alu_rrf, 1'b1,
				pic_decode_pkg::flow_seq); // rrf
			14'b00_0010_????_????: decoded = byte_op(pic_decode_pkg::alu_sub, 1'b1,
				pic_decode_pkg::flow_seq); // subwf
			14'b00_1110_????_????: decoded = byte_op(pic_decode_pkg::alu_swapf, 1'b0,
				pic_decode_pkg::flow_seq); // swapf leaves status alone
			14'b00_0110_????_????: decoded = byte_op(pic_decode_pkg::alu_xor, 1'b1,
				pic_decode_pkg::flow_seq); // xorwf
			14'b00_0000_1???_????: decoded = rec(1'b0, pic_decode_pkg::alu_passw, 1'b0,
				pic_decode_pkg::dest_f, pic_decode_pkg::flow_seq); // movwf, no status
			// bit ops, bit number in 9:7
			14'b01_00??_????_????: decoded = rec(1'b0, pic_decode_pkg::alu_bc, 1'b1,
				pic_decode_pkg::dest_f, pic_decode_pkg::flow_seq); // bcf
			14'b01_01??_????_????: decoded = rec(1'b0, pic_decode_pkg::alu_bs, 1'b1,
				pic_decode_pkg::dest_f, pic_decode_pkg::flow_seq); // bsf
			14'b01_10??_????_????: decoded = rec(1'b0, pic_decode_pkg::alu_bc, 1'b0,
				pic_decode_pkg::dest_none, pic_decode_pkg::flow_skip_bit); // btfsc, test only
			14'b01_11??_????_????: decoded = rec(1'b0, pic_decode_pkg::alu_bs, 1'b0,
				pic_decode_pkg::dest_none, pic_decode_pkg::flow_skip_bit); // btfss, test only
			// literal ops, k in 7:0
			14'b11_111?_????_????: decoded = lit_op(pic_decode_pkg::alu_add, 1'b1,
				pic_decode_pkg::flow_seq); // addlw
			14'b11_1001_????_????: decoded = lit_op(pic_decode_pkg::alu_and, 1'b1,
				pic_decode_pkg::flow_seq); // andlw
			14'b11_1000_????_????: decoded = lit_op(pic_decode_pkg::alu_or, 1'b1,
				pic_decode_pkg::flow_seq); // iorlw
			14'b11_00??_????_????: decoded = lit_op(pic_decode_pkg::alu_passlf, 1'b0,
				pic_decode_pkg::flow_seq); // movlw
			14'b11_01??_????_????: decoded = lit_op(pic_decode_pkg::alu_passlf, 1'b0,
				pic_decode_pkg::flow_ret); // retlw, k to w then pop
			14'b11_110?_????_????: decoded = lit_op(pic_decode_pkg::alu_sub, 1'b1,
				pic_decode_pkg::flow_seq); // sublw, k - w
			14'b11_1010_????_????: decoded = lit_op(pic_decode_pkg::alu_xor, 1'b1,
				pic_decode_pkg::flow_seq); // xorlw
			// control words
			14'b00_0000_0??0_0000: decoded = ctl_op(pic_decode_pkg::flow_seq); // nop
			14'b10_1???_????_????: decoded = ctl_op(pic_decode_pkg::flow_jump); // goto
			14'b10_0???_????_????: decoded = ctl_op(pic_decode_pkg::flow_call); // call
			14'b00_0000_0000_1000: decoded = ctl_op(pic_decode_pkg::flow_ret); // return
			14'b00_0000_0000_1001: decoded = ctl_op(pic_decode_pkg::flow_retfie); // retfie
			default: decoded = '0; // clrwdt, sleep and anything unlisted
		endcase
	end

endmodule

// ==== verilog/pic_decode_consts.svh ====
`ifndef PIC_DECODE_CONSTS_SVH
`define PIC_DECODE_CONSTS_SVH

// instruction word
`define PIC_INSTR_W 14 // mid-range program word

// Q phase counter
`define PIC_PHASE_W 2 // four phases per instruction cycle
`define PIC_PH_EXEC 2 // alu controls and register writes
`define PIC_PH_SEQ 3 // fetch, flush and pc controls

// instruction fields
`define PIC_DEST_BIT 7 // d bit of byte ops, 0 to w, 1 to f

// alu control
`define PIC_ALU_OP_W 4 // alu opcode width

`endif

// ==== verilog/pic_decode_pkg.sv ====
`include "pic_decode_consts.svh"

package pic_decode_pkg;

	typedef logic [`PIC_INSTR_W-1:0] instr_t; // raw program word

	// alu function select, encoding shared with the alu
	typedef enum logic [`PIC_ALU_OP_W-1:0] {
		alu_add, // w + f or w + k
		alu_and,
		alu_zero, // clrf, clrw
		alu_com, // ones complement
		alu_dec,
		alu_inc,
		alu_or,
		alu_passlf, // pass literal or f as selected
		alu_passw, // movwf
		alu_rlf, // rotate left through carry
		alu_rrf, // rotate right through carry
		alu_sub,
		alu_swapf, // nibble swap
		alu_xor,
		alu_bc, // bit clear, also btfsc test
		alu_bs // bit set, also btfss test
	} alu_op_e;

	// how the sequencing phase finishes the instruction
	typedef enum logic [2:0] {
		flow_none, // unknown word, nothing happens
		flow_seq, // pc + 1, interrupt can be taken
		flow_skip_z, // decfsz, incfsz
		flow_skip_bit, // btfsc, btfss
		flow_jump, // goto
		flow_call,
		flow_ret, // return, retlw
		flow_retfie
	} flow_e;

	// alu inputs, 6 bits
	typedef struct packed {
		logic sel_l; // 1 literal, 0 file register
		alu_op_e op;
		logic status_wr_en; // update z, c, dc
	} alu_ctrl_t;

	// where the alu result goes
	typedef enum logic [1:0] {
		dest_none,
		dest_w,
		dest_f,
		dest_by_d // follow the d bit
	} dest_e;

	// one decoded instruction, 11 bits
	typedef struct packed {
		alu_ctrl_t alu;
		dest_e dest;
		flow_e flow;
	} decoded_t;

	// phase 3 controls, 9 bits
	typedef struct packed {
		logic instr_rd_en; // latch next program word
		logic instr_flush; // drop prefetched word
		logic pc_incr_en;
		logic pc_j_en; // load jump target
		logic pc_j_and_push_en; // load target, push return address
		logic pc_j_by_pop_en; // load from stack
		logic pc_j_to_isr; // load interrupt vector
		logic gie_set_en;
		logic gie_clr_en;
	} seq_ctrl_t;

endpackage

// ==== verilog/q_phase_gen.sv ====
`timescale 1ns/1ps
`include "pic_decode_consts.svh"

module q_phase_gen (
	input logic clk,
	input logic rst,
	output logic [`PIC_PHASE_W-1:0] phase,
	output logic clkout
);

	// q1..q4 of the instruction cycle, counted as 0..3
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0; // restart at q1
		end else begin
			phase <= phase + `PIC_PHASE_W'(1); // wraps 3 -> 0
		end
	end

	// fosc/4, high for the first half of the cycle
	assign clkout = ~phase[`PIC_PHASE_W-1]; // high in phases 0 and 1

endmodule

// ==== verilog/seq_ctrl_gen.sv ====
`timescale 1ns/1ps
`include "pic_decode_consts.svh"

module seq_ctrl_gen (
	input logic [`PIC_PHASE_W-1:0] phase,
	input pic_decode_pkg::flow_e flow,
	input logic interrupt_flag,
	input logic status_z,
	input logic bit_test_res,
	output pic_decode_pkg::seq_ctrl_t seq
);

	logic seq_ph; // q4 of the cycle
	logic skip_cond; // skip taken for this word

	assign seq_ph = (phase == `PIC_PHASE_W'(`PIC_PH_SEQ));

	// z for decfsz/incfsz, tested bit for btfsc/btfss
	assign skip_cond = (flow == pic_decode_pkg::flow_skip_z) ? status_z : bit_test_res;

	always_comb begin
		seq = '0;
		if (seq_ph) begin
			case (flow)
				pic_decode_pkg::flow_seq: begin
					if (interrupt_flag) begin // interrupt entry after single-cycle op
						seq.instr_flush = 1'b1;
						seq.pc_j_to_isr = 1'b1;
						seq.gie_clr_en = 1'b1; // no nesting
					end else begin
						seq.instr_rd_en = 1'b1;
						seq.pc_incr_en = 1'b1;
					end
				end
				pic_decode_pkg::flow_skip_z,
				pic_decode_pkg::flow_skip_bit: begin
					// interrupt not taken on a skip
					seq.pc_incr_en = 1'b1;
					seq.instr_flush = skip_cond; // next word becomes a nop
					seq.instr_rd_en = ~skip_cond;
				end
				pic_decode_pkg::flow_jump: begin
					seq.instr_flush = 1'b1;
					seq.pc_j_en = 1'b1; // goto target from k
				end
				pic_decode_pkg::flow_call: begin
					seq.instr_flush = 1'b1;
					seq.pc_j_and_push_en = 1'b1;
				end
				pic_decode_pkg::flow_ret: begin
					seq.instr_flush = 1'b1;
					seq.pc_j_by_pop_en = 1'b1; // top of stack
				end
				pic_decode_pkg::flow_retfie: begin
					seq.instr_flush = 1'b1;
					seq.pc_j_by_pop_en = 1'b1;
					seq.gie_set_en = 1'b1; // interrupts back on
				end
				default: seq = '0; // unknown word
			endcase
		end
	end

endmodule
